// File: verilog/regexec_pkg.sv
package regexec_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int DATA_W   = 32; // Register and bus width
	localparam int ADDR_W   = 5;  // Register index width
	localparam int NUM_REGS = 32; // One per index
	localparam int IMM_W    = 16; // Immediate field, MIPS style

	//////////////////////////////
	// Operations
	//////////////////////////////

	// Register ops read rs and rt, immediate ops read rs only
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0, // rd = rs + rt
		OP_SUB  = 3'd1, // rd = rs - rt
		OP_AND  = 3'd2, // rd = rs & rt
		OP_OR   = 3'd3, // rd = rs | rt
		OP_SLT  = 3'd4, // Signed compare, 1 or 0
		OP_ADDI = 3'd5, // rd = rs + sext(imm)
		OP_LUI  = 3'd6, // rd = {imm, 16'h0}
		OP_DUMP = 3'd7  // Stream out all registers
	} alu_op_e;

	//////////////////////////////
	// Bundles
	//////////////////////////////

	// One command per strobe
	typedef struct packed {
		alu_op_e            op;
		logic [ADDR_W-1:0]  rs;  // First source
		logic [ADDR_W-1:0]  rt;  // Second source, unused by immediates
		logic [ADDR_W-1:0]  rd;  // Destination
		logic [IMM_W-1:0]   imm; // Only for ADDI and LUI
	} cmd_t;

	// One streamed register during a dump
	typedef struct packed {
		logic [ADDR_W-1:0] index;
		logic [DATA_W-1:0] data;
	} dump_t;

endpackage

// File: verilog/register_file.sv
`timescale 1ns/1ns

// 32 x 32 register file, two async reads, one sync write
module register_file import regexec_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              we,      // Write enable
	input  logic [ADDR_W-1:0] raddr_a, // Port A address
	input  logic [ADDR_W-1:0] raddr_b, // Port B address
	input  logic [ADDR_W-1:0] waddr,   // Destination register
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata_a,
	output logic [DATA_W-1:0] rdata_b
);

	logic [DATA_W-1:0] regs [NUM_REGS]; // Storage array

	//////////////////////////////
	// Write port
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0; // Whole file clears
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata; // r0 never written
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////

	// r0 is hardwired zero on both ports
	always_comb begin
		rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
		rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];
	end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns

// Combinational ALU, results wrap modulo 2**32
module alu import regexec_pkg::*; (
	input  alu_op_e           op,
	input  logic [DATA_W-1:0] a,   // rs value
	input  logic [DATA_W-1:0] b,   // rt value
	input  logic [IMM_W-1:0]  imm,
	output logic [DATA_W-1:0] y
);

	logic [DATA_W-1:0] imm_sext; // Sign-extended immediate
	logic [DATA_W-1:0] opnd_b;   // Second operand after select

	assign imm_sext = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};

	// ADDI takes the immediate, everything else rt
	assign opnd_b = (op == OP_ADDI) ? imm_sext : b;

	always_comb begin
		case (op)
			OP_ADD, OP_ADDI: y = a + opnd_b;
			OP_SUB:          y = a - opnd_b;
			OP_AND:          y = a & opnd_b;
			OP_OR:           y = a | opnd_b;
			OP_SLT: begin
				// Signed compare, zero-extended flag
				y = ($signed(a) < $signed(opnd_b)) ? DATA_W'(1) : '0;
			end
			OP_LUI:          y = {imm, {(DATA_W-IMM_W){1'b0}}}; // Low half zero
			default:         y = a; // Dump, pass port A through
		endcase
	end

endmodule

// File: verilog/dump_counter.sv
`timescale 1ns/1ns

// Walks the register index 0..31 once per start pulse
module dump_counter import regexec_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,  // One-cycle kick
	output logic              active, // Count in progress
	output logic [ADDR_W-1:0] index,
	output logic              last    // Final index this cycle
);

	// Last register reached while counting
	assign last = active && (index == ADDR_W'(NUM_REGS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			index  <= '0;
		end else if (start) begin
			active <= 1'b1;
			index  <= '0; // Restart from r0
		end else if (active) begin
			index <= index + 1'b1; // Wraps back to 0 after 31
			if (last) begin
				active <= 1'b0; // Done after index 31
			end
		end
	end

endmodule

// File: verilog/exec_control.sv
`timescale 1ns/1ns

// Command sequencer: accept, execute/writeback, done, or dump stream
module exec_control import regexec_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              cmd_valid,
	input  cmd_t              cmd,
	input  logic              cnt_active, // From dump counter
	input  logic              cnt_last,
	input  logic [ADDR_W-1:0] cnt_index,
	input  logic [DATA_W-1:0] alu_y,
	input  logic [DATA_W-1:0] rdata_a,
	output logic              cnt_start,
	output logic [ADDR_W-1:0] raddr_a,
	output logic [ADDR_W-1:0] raddr_b,
	output alu_op_e           op,
	output logic [IMM_W-1:0]  imm,
	output logic              we,
	output logic [ADDR_W-1:0] waddr,
	output logic              busy,
	output logic              done,
	output logic              dump_valid,
	output logic [DATA_W-1:0] result,
	output dump_t             dump
);

	typedef enum logic [1:0] {IDLE, EXEC, DONE, DUMP} state_e;

	state_e state;
	state_e state_next;
	cmd_t   cmd_q;  // Latched command
	logic   accept; // Command taken this cycle

	//////////////////////////////
	// Accept and FSM
	//////////////////////////////

	assign accept    = cmd_valid && (state == IDLE); // Dropped while busy
	assign cnt_start = accept && (cmd.op == OP_DUMP);

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (accept) begin
					state_next = (cmd.op == OP_DUMP) ? DUMP : EXEC;
				end
			end
			EXEC: state_next = DONE; // Writeback lands this cycle
			DUMP: begin
				if (cnt_last) begin
					state_next = DONE; // done rides with entry 31
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= IDLE;
			dump_valid <= 1'b0;
		end else begin
			state      <= state_next;
			dump_valid <= (state == DUMP) && cnt_active; // One behind counter
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (accept) cmd_q <= cmd;
		if (state == EXEC) result <= alu_y; // Held for the done cycle
		if (state == DUMP) begin
			dump.index <= cnt_index;
			dump.data  <= rdata_a;
		end
	end

	//////////////////////////////
	// Datapath steering
	//////////////////////////////

	assign raddr_a = (state == DUMP) ? cnt_index : cmd_q.rs; // Counter owns port A in dump
	assign raddr_b = cmd_q.rt;
	assign op      = cmd_q.op;
	assign imm     = cmd_q.imm;
	assign we      = (state == EXEC);
	assign waddr   = cmd_q.rd;
	assign busy    = (state != IDLE);
	assign done    = (state == DONE);

endmodule

// File: verilog/reg_exec_top.sv
`timescale 1ns/1ns

// Register file execution subsystem, wiring only
module reg_exec_top import regexec_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              cmd_valid, // Command strobe
	input  cmd_t              cmd,
	output logic              busy,      // Commands dropped while high
	output logic              done,
	output logic [DATA_W-1:0] result,
	output logic              dump_valid,
	output dump_t             dump
);

	//////////////////////////////
	// Internal wires
	//////////////////////////////

	logic              cnt_start;
	logic              cnt_active;
	logic              cnt_last;
	logic [ADDR_W-1:0] cnt_index;
	logic [ADDR_W-1:0] raddr_a;
	logic [ADDR_W-1:0] raddr_b;
	logic [ADDR_W-1:0] waddr;
	logic              we;
	logic [DATA_W-1:0] rdata_a;
	logic [DATA_W-1:0] rdata_b;
	logic [DATA_W-1:0] alu_y;    // Also the write data
	alu_op_e           op;
	logic [IMM_W-1:0]  imm;

	exec_control u_ctrl (
		.clk, .reset, .cmd_valid, .cmd,
		.cnt_active, .cnt_last, .cnt_index,
		.alu_y, .rdata_a,
		.cnt_start, .raddr_a, .raddr_b, .op, .imm,
		.we, .waddr,
		.busy, .done, .dump_valid, .result, .dump
	);

	dump_counter u_cnt (
		.clk, .reset,
		.start  (cnt_start),
		.active (cnt_active),
		.index  (cnt_index),
		.last   (cnt_last)
	);

	register_file u_rf (
		.clk, .reset, .we,
		.raddr_a, .raddr_b, .waddr,
		.wdata (alu_y), // Writeback straight from ALU
		.rdata_a, .rdata_b
	);

	alu u_alu (
		.op, .imm,
		.a (rdata_a),
		.b (rdata_b),
		.y (alu_y)
	);

endmodule

// File: verif/reg_exec_assert.sv
`timescale 1ns/1ns

// Protocol checks on the top level outputs
module reg_exec_assert (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done,
	input logic dump_valid
);

	int fail_count = 0; // Read by the testbench summary

	// done lasts exactly one cycle
	a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else begin
			$error("done stayed high for more than one cycle");
			fail_count++;
		end

	// Stream only starts inside a command
	a_dump_in_busy: assert property (@(posedge clk) disable iff (reset)
		$rose(dump_valid) |-> busy)
		else begin
			$error("dump_valid rose while busy was low");
			fail_count++;
		end

	a_done_busy: assert property (@(posedge clk) disable iff (reset) done |-> busy)
		else begin
			$error("done seen without busy");
			fail_count++;
		end

	// Back to idle right after done
	a_busy_falls: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
		else begin
			$error("busy did not fall in the cycle after done");
			fail_count++;
		end

endmodule

// File: verif/reg_exec_tb.sv
`timescale 1ns/1ns

module reg_exec_tb import regexec_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY  = 2;  // Input skew after rising edge
	localparam int OP_CYC     = 5;  // Budget per ALU command
	localparam int DUMP_CYC   = 40; // Budget per dump
	localparam int TEST_CYC   = 20 + 3 * DUMP_CYC + (62 + 37 + 4 + 3) * OP_CYC;

	logic              clk;
	logic              reset;
	logic              cmd_valid;
	cmd_t              cmd;
	logic              busy;
	logic              done;
	logic [DATA_W-1:0] result;
	logic              dump_valid;
	dump_t             dump;

	logic [DATA_W-1:0] model [NUM_REGS]; // Expected register contents
	logic [31:0]       lcg_state = 32'h8bdb5a0b;
	int                error_count = 0;

	reg_exec_top dut (.*);

	bind reg_exec_top reg_exec_assert u_assert (.clk, .reset, .busy, .done, .dump_valid);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Expected value straight from the operation rules
	function logic [DATA_W-1:0] model_result(input alu_op_e op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [IMM_W-1:0] imm);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_ADDI: return a + {{16{imm[15]}}, imm}; // Sign-extended immediate
			OP_LUI:  return {imm, 16'h0000};
			default: return '0;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act)
			else begin
				$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
				error_count++;
			end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic wait_idle(input string name);
		int n;
		n = 0;
		while (busy && n < 64) begin
			next_cycle();
			n++;
		end
		assert (!busy)
			else begin
				$display("%s: DUT never left busy, command issued anyway", name);
				error_count++;
			end
	endtask

	// One-cycle strobe, returns in the cycle after acceptance
	task automatic strobe_cmd(input cmd_t c);
		cmd_valid = 1'b1;
		cmd       = c;
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	task automatic run_op(input string name, input alu_op_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [15:0] imm);
		logic [DATA_W-1:0] expected;
		int                cycles;
		cmd_t              c;
		expected = model_result(op, model[rs], model[rt], imm);
		c = '{op: op, rs: rs, rt: rt, rd: rd, imm: imm};
		wait_idle(name);
		strobe_cmd(c);
		cycles = 1;
		while (!done && cycles < 8) begin
			next_cycle();
			cycles++;
		end
		check_val(name, 2, cycles); // done two cycles after accept
		check_val(name, expected, result);
		if (rd != 0) model[rd] = expected; // r0 stays zero
		next_cycle();
	endtask

	task automatic run_dump(input string name);
		int   cycles;
		cmd_t c;
		c    = '0;
		c.op = OP_DUMP;
		wait_idle(name);
		strobe_cmd(c);
		cycles = 1;
		while (!dump_valid && cycles < 8) begin
			next_cycle();
			cycles++;
		end
		check_val(name, 2, cycles); // First entry in cycle 2
		for (int i = 0; i < NUM_REGS; i++) begin
			check_val(name, 1, dump_valid);
			check_val(name, i, dump.index);
			check_val(name, model[i], dump.data);
			check_val(name, (i == NUM_REGS - 1), done); // done rides with r31
			next_cycle();
		end
		check_val(name, 0, busy);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic test_reset_state();
		check_val("reset_state", 0, busy);
		check_val("reset_state", 0, done);
		check_val("reset_state", 0, dump_valid);
		run_dump("reset_state");
	endtask

	task automatic test_immediate_loads();
		logic [31:0] rnd;
		for (int r = 1; r < NUM_REGS; r++) begin
			rnd = next_rand();
			run_op("imm_loads", OP_LUI, 5'd0, 5'd0, r[4:0], rnd[15:0]);
			run_op("imm_loads", OP_ADDI, r[4:0], 5'd0, r[4:0], rnd[31:16]);
		end
	endtask

	task automatic test_register_ops();
		logic [31:0] rnd;
		run_op("reg_ops", OP_LUI, 5'd0, 5'd0, 5'd1, 16'h8000);
		run_op("reg_ops", OP_ADDI, 5'd1, 5'd0, 5'd1, 16'hffff); // Max positive
		run_op("reg_ops", OP_LUI, 5'd0, 5'd0, 5'd2, 16'h8000);  // Most negative
		run_op("reg_ops", OP_ADD, 5'd1, 5'd1, 5'd3, 16'h0);     // Signed overflow
		run_op("reg_ops", OP_SUB, 5'd2, 5'd1, 5'd4, 16'h0);     // Wraps to 1
		run_op("reg_ops", OP_SLT, 5'd2, 5'd1, 5'd5, 16'h0);
		run_op("reg_ops", OP_SLT, 5'd1, 5'd2, 5'd6, 16'h0);
		for (int n = 0; n < 30; n++) begin
			rnd = next_rand();
			run_op("reg_ops", alu_op_e'(rnd % 5), rnd[9:5], rnd[14:10], rnd[19:15], 16'h0);
		end
	endtask

	task automatic test_register_zero();
		run_op("reg_zero", OP_ADDI, 5'd5, 5'd0, 5'd0, 16'h7abc); // Result shown, not stored
		run_op("reg_zero", OP_ADD, 5'd0, 5'd0, 5'd9, 16'h0);
		run_op("reg_zero", OP_ADDI, 5'd0, 5'd0, 5'd10, 16'h1234);
		run_op("reg_zero", OP_OR, 5'd0, 5'd3, 5'd11, 16'h0);
	endtask

	task automatic test_dropped_cmds();
		logic [DATA_W-1:0] expected;
		cmd_t              c1;
		cmd_t              c2;
		c1 = '{op: OP_ADDI, rs: 5'd12, rt: 5'd0, rd: 5'd13, imm: 16'h0042};
		c2 = '{op: OP_LUI, rs: 5'd0, rt: 5'd0, rd: 5'd14, imm: 16'hdead};
		expected = model_result(OP_ADDI, model[12], '0, 16'h0042);
		wait_idle("dropped_cmds");
		strobe_cmd(c1);
		strobe_cmd(c2);   // Cycle 1, busy
		check_val("dropped_cmds", 1, done);
		check_val("dropped_cmds", expected, result);
		model[13] = expected;
		strobe_cmd(c2);   // Cycle 2, still busy
		check_val("dropped_cmds", 0, busy);
		check_val("dropped_cmds", 0, done);
		run_dump("dropped_cmds"); // r14 must be untouched
	endtask

	//////////////////////////////
	// Clock, watchdog, main
	//////////////////////////////

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(2 * TEST_CYC * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

	initial begin
		reset     = 1'b1;
		cmd_valid = 1'b0;
		cmd       = '0;
		for (int i = 0; i < NUM_REGS; i++) model[i] = '0;
		repeat (10) @(posedge clk);
		#DRIVE_DLY;
		reset = 1'b0;
		next_cycle();
		test_reset_state();
		test_immediate_loads();
		test_register_ops();
		test_register_zero();
		test_dropped_cmds();
		$display("Check errors: %0d, assertion failures: %0d", error_count,
			dut.u_assert.fail_count);
		if (error_count == 0 && dut.u_assert.fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: files.f
verilog/regexec_pkg.sv
verilog/register_file.sv
verilog/alu.sv
verilog/dump_counter.sv
verilog/exec_control.sv
verilog/reg_exec_top.sv
verif/reg_exec_assert.sv
verif/reg_exec_tb.sv

// File: Bender.yml
package:
  name: reg_exec

sources:
  - verilog/regexec_pkg.sv
  - verilog/register_file.sv
  - verilog/alu.sv
  - verilog/dump_counter.sv
  - verilog/exec_control.sv
  - verilog/reg_exec_top.sv
  - target: test
    files:
      - verif/reg_exec_assert.sv
      - verif/reg_exec_tb.sv
